//--- design/vending_consts.svh
`ifndef VENDING_CONSTS_SVH
`define VENDING_CONSTS_SVH

// Number of snack slots, coded 00 to 19
`define SLOT_COUNT 20

// Weight of the first keyed digit when the slot code is formed
`define DIGIT_RADIX 10

// Units placed in every slot by a reload
`define STOCK_FULL 10

// Cycles allowed for each digit, for the bank approval and for the door
`define ENTRY_WINDOW 5

// Each band macro gives the first slot of the next higher price
// Slots below the first band cost 1 and slots from the last band on cost 6
`define PRICE_BAND_1 4
`define PRICE_BAND_2 8
`define PRICE_BAND_3 12
`define PRICE_BAND_4 16
`define PRICE_BAND_5 18

`endif

//--- design/vending_pkg.sv
`default_nettype none

package vending_pkg;

	// One digit from the keypad
	typedef logic [3:0] digit_t;

	// Combined slot code
	// Wide enough for the largest keyable pair 15 * 10 + 15
	typedef logic [7:0] slot_code_t;

	// Units left in one slot, up to a full load of ten
	typedef logic [3:0] stock_t;

	// Price shown on COST, from 1 to 6
	typedef logic [2:0] price_t;

	// Cycle count inside one waiting window
	typedef logic [2:0] window_count_t;

	// Transaction states of the sequencer
	typedef enum logic [3:0] {
		st_idle,
		st_cleared,
		st_reloading,
		st_entering,
		st_checking,
		st_rejected,
		st_awaiting_approval,
		st_vending,
		st_door_open,
		st_declined
	} vend_state_t;

endpackage

`default_nettype wire

//--- design/window_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "vending_consts.svh"

// Counts the cycles of one waiting window and flags the last one
module window_timer
	import vending_pkg::*;
(
	input  wire logic CLK,
	input  wire logic RESET,
	input  wire logic restart,
	input  wire logic run,
	output logic      expired
);

	window_count_t count_q;

	// The window runs out on the cycle the count sits at its last value while running
	// The owner sees the flag in that same cycle and may still accept an input there
	assign expired = run && (count_q == window_count_t'(`ENTRY_WINDOW - 1));

	always_ff @(posedge CLK)
	begin
		// Restart wins over run so a new window always begins from zero
		if (RESET || restart)
			count_q <= '0;
		else if (run)
		begin
			// Wrap to zero after the last cycle so the flag is a single pulse
			if (expired)
				count_q <= '0;
			else
				count_q <= count_q + window_count_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- design/key_entry.sv
`timescale 1ns/10ps
`default_nettype none

`include "vending_consts.svh"

// Takes two keyed digits, each inside its own window, and forms the slot code
module key_entry
	import vending_pkg::*;
(
	input  wire logic       CLK,
	input  wire logic       RESET,
	input  wire logic       entry_start,
	input  wire logic       key_press,
	input  wire digit_t     item_code,
	output logic            code_ready,
	output logic            entry_timeout,
	output slot_code_t      slot_code
);

	// Local two step machine, idle between transactions
	typedef enum logic [1:0] {
		key_idle,
		key_first,
		key_second
	} entry_state_t;

	entry_state_t state_q;
	digit_t       first_digit_q;
	logic         key_taken;
	logic         window_restart;
	logic         window_run;
	logic         window_expired;

	// A key only counts while a digit is awaited
	// The entry_start cycle itself is not part of any window
	assign key_taken = key_press && (state_q != key_idle) && !entry_start;

	// Each accepted digit opens a fresh window for the next one
	assign window_restart = entry_start || key_taken;
	assign window_run = (state_q != key_idle);

	window_timer digit_timer_inst (
		.CLK     (CLK),
		.RESET   (RESET),
		.restart (window_restart),
		.run     (window_run),
		.expired (window_expired)
	);

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state_q <= key_idle;
			code_ready <= 1'b0;
			entry_timeout <= 1'b0;
		end
		else
		begin
			// Both answers are single cycle pulses
			code_ready <= 1'b0;
			entry_timeout <= 1'b0;
			if (entry_start)
				state_q <= key_first;
			else if (key_taken)
			begin
				case (state_q)
					key_first:
						state_q <= key_second;
					default:
					begin
						// Second digit is in so the code is complete
						state_q <= key_idle;
						code_ready <= 1'b1;
					end
				endcase
			end
			else if (window_expired)
			begin
				// Window ran out with no key in either digit position
				state_q <= key_idle;
				entry_timeout <= 1'b1;
			end
		end
	end

	// Digit capture and code forming
	// The code stays put until a later entry overwrites it
	always_ff @(posedge CLK)
	begin
		if (key_taken && (state_q == key_first))
			first_digit_q <= item_code;
		if (key_taken && (state_q == key_second))
			slot_code <= slot_code_t'(first_digit_q) * slot_code_t'(`DIGIT_RADIX)
				+ slot_code_t'(item_code);
	end

endmodule

`default_nettype wire

//--- design/slot_inventory.sv
`timescale 1ns/10ps
`default_nettype none

`include "vending_consts.svh"

// Stock per slot with clear, reload and decrement, plus the selection check
module slot_inventory
	import vending_pkg::*;
(
	input  wire logic       CLK,
	input  wire logic       RESET,
	input  wire logic       stock_clear,
	input  wire logic       stock_fill,
	input  wire logic       selection_check,
	input  wire logic       vend_take,
	input  wire slot_code_t slot_code,
	output logic            slot_ok,
	output price_t          slot_price
);

	stock_t stock_q [`SLOT_COUNT];
	stock_t selected_stock;
	logic   in_range;

	// Price from the slot bands
	// Codes past the last slot fall in the top band but are never accepted
	function automatic price_t band_price(input slot_code_t code);
		price_t price;
		if (code < slot_code_t'(`PRICE_BAND_1))
			price = price_t'(1);
		else if (code < slot_code_t'(`PRICE_BAND_2))
			price = price_t'(2);
		else if (code < slot_code_t'(`PRICE_BAND_3))
			price = price_t'(3);
		else if (code < slot_code_t'(`PRICE_BAND_4))
			price = price_t'(4);
		else if (code < slot_code_t'(`PRICE_BAND_5))
			price = price_t'(5);
		else
			price = price_t'(6);
		return price;
	endfunction

	assign in_range = (slot_code < slot_code_t'(`SLOT_COUNT));

	// Read mux over the table
	// The code is compared against every slot so no index ever leaves the table
	always_comb
	begin
		selected_stock = '0;
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			if (slot_code == slot_code_t'(i))
				selected_stock = stock_q[i];
		end
	end

	// Stock table
	// Clearing beats reload and reload beats a vend
	always_ff @(posedge CLK)
	begin
		for (int i = 0; i < `SLOT_COUNT; i++)
		begin
			if (RESET || stock_clear)
				stock_q[i] <= '0;
			else if (stock_fill)
				stock_q[i] <= stock_t'(`STOCK_FULL);
			else if (vend_take && (slot_code == slot_code_t'(i)) && (stock_q[i] != '0))
				stock_q[i] <= stock_q[i] - stock_t'(1);
		end
	end

	// Result of the check is held until the next check
	always_ff @(posedge CLK)
	begin
		if (RESET)
			slot_ok <= 1'b0;
		else if (selection_check)
			slot_ok <= in_range && (selected_stock != '0);
	end

	// Price is captured with the check so it matches the held verdict
	always_ff @(posedge CLK)
	begin
		if (selection_check)
			slot_price <= band_price(slot_code);
	end

endmodule

`default_nettype wire

//--- design/vend_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

// Transaction FSM of the vending controller
// It owns the four machine outputs and steers key entry and the inventory
module vend_sequencer
	import vending_pkg::*;
(
	input  wire logic   CLK,
	input  wire logic   RESET,
	input  wire logic   card_in,
	input  wire logic   valid_tran,
	input  wire logic   door_open,
	input  wire logic   reload,
	input  wire logic   code_ready,
	input  wire logic   entry_timeout,
	input  wire logic   slot_ok,
	input  wire price_t slot_price,
	output logic        entry_start,
	output logic        selection_check,
	output logic        vend_take,
	output logic        stock_clear,
	output logic        stock_fill,
	output logic        vend,
	output logic        invalid_sel,
	output logic        failed_tran,
	output price_t      cost
);

	vend_state_t state_q;
	vend_state_t state_d;
	logic        wait_restart;
	logic        wait_run;
	logic        wait_expired;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			// One cycle to empty the table after reset
			st_cleared:
				state_d = st_idle;
			st_idle:
			begin
				// Reload has priority over a new card
				if (reload)
					state_d = st_reloading;
				else if (card_in)
					state_d = st_entering;
			end
			st_reloading:
				state_d = st_idle;
			st_entering:
			begin
				if (entry_timeout)
					state_d = st_rejected;
				else if (code_ready)
					state_d = st_checking;
			end
			// The check result from the inventory is valid in this state
			st_checking:
			begin
				if (slot_ok)
					state_d = st_awaiting_approval;
				else
					state_d = st_rejected;
			end
			st_rejected:
				state_d = st_idle;
			st_awaiting_approval:
			begin
				// Approval on the last window cycle still counts
				if (valid_tran)
					state_d = st_vending;
				else if (wait_expired)
					state_d = st_declined;
			end
			st_vending:
			begin
				// Door never opened so the item is left and the machine gives up
				if (door_open)
					state_d = st_door_open;
				else if (wait_expired)
					state_d = st_idle;
			end
			st_door_open:
			begin
				if (!door_open)
					state_d = st_idle;
			end
			st_declined:
				state_d = st_idle;
			default:
				state_d = st_idle;
		endcase
	end

	// Inventory controls follow the state and the inputs directly
	assign selection_check = (state_q == st_entering) && code_ready;
	assign vend_take = (state_q == st_awaiting_approval) && valid_tran;
	assign stock_clear = (state_q == st_cleared);
	assign stock_fill = (state_q == st_reloading);

	// One timer serves the approval window and the door window
	// Every state change restarts it so each wait opens fresh
	assign wait_restart = (state_d != state_q);
	assign wait_run = (state_q == st_awaiting_approval) || (state_q == st_vending);

	window_timer wait_timer_inst (
		.CLK     (CLK),
		.RESET   (RESET),
		.restart (wait_restart),
		.run     (wait_run),
		.expired (wait_expired)
	);

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state_q <= st_cleared;
			entry_start <= 1'b0;
			vend <= 1'b0;
			invalid_sel <= 1'b0;
			failed_tran <= 1'b0;
			cost <= '0;
		end
		else
		begin
			state_q <= state_d;
			// Pulse on the way into digit entry
			entry_start <= (state_q == st_idle) && (state_d == st_entering);
			// Outputs are registered copies of the next state
			vend <= (state_d == st_vending);
			invalid_sel <= (state_d == st_rejected);
			failed_tran <= (state_d == st_declined);
			// Price shows from the approval wait until the machine is idle again
			if ((state_q == st_checking) && (state_d == st_awaiting_approval))
				cost <= slot_price;
			else if (state_d == st_idle)
				cost <= '0;
		end
	end

endmodule

`default_nettype wire

//--- design/vending_machine.sv
`timescale 1ns/10ps
`default_nettype none

// Top of the snack vending controller
// Key entry feeds the sequencer and the sequencer drives the inventory and outputs
module vending_machine
	import vending_pkg::*;
(
	input  wire logic   CLK,
	input  wire logic   RESET,
	input  wire logic   CARD_IN,
	input  wire logic   VALID_TRAN,
	input  wire digit_t ITEM_CODE,
	input  wire logic   KEY_PRESS,
	input  wire logic   DOOR_OPEN,
	input  wire logic   RELOAD,
	output wire logic   VEND,
	output wire logic   INVALID_SEL,
	output wire logic   FAILED_TRAN,
	output wire price_t COST
);

	// Key entry handshake
	logic       entry_start;
	logic       code_ready;
	logic       entry_timeout;
	slot_code_t slot_code;

	// Inventory controls and results
	logic       selection_check;
	logic       vend_take;
	logic       stock_clear;
	logic       stock_fill;
	logic       slot_ok;
	price_t     slot_price;

	key_entry key_entry_inst (
		.CLK           (CLK),
		.RESET         (RESET),
		.entry_start   (entry_start),
		.key_press     (KEY_PRESS),
		.item_code     (ITEM_CODE),
		.code_ready    (code_ready),
		.entry_timeout (entry_timeout),
		.slot_code     (slot_code)
	);

	slot_inventory slot_inventory_inst (
		.CLK             (CLK),
		.RESET           (RESET),
		.stock_clear     (stock_clear),
		.stock_fill      (stock_fill),
		.selection_check (selection_check),
		.vend_take       (vend_take),
		.slot_code       (slot_code),
		.slot_ok         (slot_ok),
		.slot_price      (slot_price)
	);

	vend_sequencer vend_sequencer_inst (
		.CLK             (CLK),
		.RESET           (RESET),
		.card_in         (CARD_IN),
		.valid_tran      (VALID_TRAN),
		.door_open       (DOOR_OPEN),
		.reload          (RELOAD),
		.code_ready      (code_ready),
		.entry_timeout   (entry_timeout),
		.slot_ok         (slot_ok),
		.slot_price      (slot_price),
		.entry_start     (entry_start),
		.selection_check (selection_check),
		.vend_take       (vend_take),
		.stock_clear     (stock_clear),
		.stock_fill      (stock_fill),
		.vend            (VEND),
		.invalid_sel     (INVALID_SEL),
		.failed_tran     (FAILED_TRAN),
		.cost            (COST)
	);

endmodule

`default_nettype wire

//--- test/vending_machine_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "vending_consts.svh"

// Testbench that runs whole transactions through the controller
// A stock model per slot predicts every verdict, price and vend
module vending_machine_tb
	import vending_pkg::*;
();

	typedef enum {p_card, p_key, p_approve, p_reload} pulse_t;
	typedef enum {w_vend, w_vend_low, w_failed, w_cost_clear} watch_t;
	typedef enum {full_sale, no_approval, door_left_shut} sale_mode_t;

	// Roughly a hundred transactions, none of which needs forty cycles
	localparam int WATCHDOG_CYCLES = 16 + 100 * 40;

	logic        CLK;
	logic        RESET;
	logic        card_in;
	logic        valid_tran;
	logic        key_press;
	logic        door_open;
	logic        reload;
	digit_t      item_code;
	logic        vend;
	logic        invalid_sel;
	logic        failed_tran;
	price_t      cost;
	price_t      expected_cost;
	int          errors;
	int          model_stock [`SLOT_COUNT];
	logic [15:0] lfsr_q;

	vending_machine vending_machine_inst (
		.CLK         (CLK),
		.RESET       (RESET),
		.CARD_IN     (card_in),
		.VALID_TRAN  (valid_tran),
		.ITEM_CODE   (item_code),
		.KEY_PRESS   (key_press),
		.DOOR_OPEN   (door_open),
		.RELOAD      (reload),
		.VEND        (vend),
		.INVALID_SEL (invalid_sel),
		.FAILED_TRAN (failed_tran),
		.COST        (cost)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#5 CLK = ~CLK;
	end

	task automatic log_mismatch(input string name, input int actual, input int expected);
		errors++;
		$display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
	endtask

	task automatic fail_check(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// Every output reads zero in the cycle after a reset cycle
	assert property (@(posedge CLK) RESET |=> {vend, invalid_sel, failed_tran, cost} == '0)
	else
		log_mismatch("{VEND,INVALID_SEL,FAILED_TRAN,COST}",
			int'($sampled({vend, invalid_sel, failed_tran, cost})), 0);

	// Rejections and declines are single cycle pulses
	assert property (@(posedge CLK) disable iff (RESET) invalid_sel |=> !invalid_sel)
	else
		log_mismatch("INVALID_SEL", int'($sampled(invalid_sel)), 0);

	assert property (@(posedge CLK) disable iff (RESET) failed_tran |=> !failed_tran)
	else
		log_mismatch("FAILED_TRAN", int'($sampled(failed_tran)), 0);

	// While the item is out the price of the chosen slot stays on COST
	assert property (@(posedge CLK) disable iff (RESET) vend |-> cost == expected_cost)
	else
		log_mismatch("COST", int'($sampled(cost)), int'(expected_cost));

	// Fibonacci LFSR with taps 16 14 13 11
	// Five steps give the bits for one slot
	function automatic int next_slot();
		int bits;
		bits = 0;
		repeat (5)
		begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			bits = (bits << 1) | int'(lfsr_q[0]);
		end
		return bits % `SLOT_COUNT;
	endfunction

	// Price starts at one and rises by one at the first slot of each band
	function automatic price_t expected_price(input int slot);
		int bands [5] = '{`PRICE_BAND_1, `PRICE_BAND_2, `PRICE_BAND_3, `PRICE_BAND_4,
			`PRICE_BAND_5};
		int price;
		price = 1;
		foreach (bands[i])
			price += int'(slot >= bands[i]);
		return price_t'(price);
	endfunction

	// Raises one control input for a single cycle, with a digit on the keypad
	task automatic pulse_input(input pulse_t which, input int digit);
		@(posedge CLK);
		item_code <= digit_t'(digit);
		card_in <= (which == p_card);
		key_press <= (which == p_key);
		valid_tran <= (which == p_approve);
		reload <= (which == p_reload);
		@(posedge CLK);
		card_in <= 1'b0;
		key_press <= 1'b0;
		valid_tran <= 1'b0;
		reload <= 1'b0;
	endtask

	function automatic logic watched_level(input watch_t which);
		case (which)
			w_vend: return vend;
			w_vend_low: return !vend;
			w_failed: return failed_tran;
			default: return (cost == '0);
		endcase
	endfunction

	// Samples at falling edges until the watched output shows or the limit runs out
	task automatic await_output(input watch_t which, input int limit);
		int waited;
		waited = 0;
		@(negedge CLK);
		while (!watched_level(which) && waited < limit)
		begin
			waited++;
			@(negedge CLK);
		end
		assert (watched_level(which))
		else
			fail_check($sformatf("%s not seen within %0d cycles", which.name(), limit));
	endtask

	// Gives 1 for INVALID_SEL, 2 for a price on COST and 0 when neither shows in time
	task automatic selection_verdict(input int limit, output int verdict);
		verdict = 0;
		for (int i = 0; i < limit && verdict == 0; i++)
		begin
			@(negedge CLK);
			if (invalid_sel)
				verdict = 1;
			else if (cost != '0)
				verdict = 2;
		end
	endtask

	// A whole transaction for one code, carried as far as the mode allows
	task automatic purchase(input int code, input sale_mode_t mode);
		int verdict;
		bit expect_ok;
		expect_ok = (code < `SLOT_COUNT) && (model_stock[code] > 0);
		pulse_input(p_card, 0);
		pulse_input(p_key, code / `DIGIT_RADIX);
		pulse_input(p_key, code % `DIGIT_RADIX);
		selection_verdict(12, verdict);
		assert (verdict != 0)
		else
			fail_check($sformatf("slot %0d gave neither INVALID_SEL nor COST", code));
		if (verdict != 0)
		begin
			assert ((verdict == 1) == !expect_ok)
			else
				log_mismatch("INVALID_SEL", int'(verdict == 1), int'(!expect_ok));
		end
		if (verdict != 2)
		begin
			// A late approval after a rejection must not vend anything
			pulse_input(p_approve, 0);
			@(negedge CLK);
			assert ({vend, failed_tran, cost} == '0)
			else
				log_mismatch("{VEND,FAILED_TRAN,COST}", int'({vend, failed_tran, cost}), 0);
			return;
		end
		assert (cost == expected_price(code))
		else
			log_mismatch("COST", int'(cost), int'(expected_price(code)));
		expected_cost = expected_price(code);
		if (mode == no_approval)
			await_output(w_failed, `ENTRY_WINDOW + 2);
		else
		begin
			pulse_input(p_approve, 0);
			await_output(w_vend, 2);
			model_stock[code]--;
			if (mode == full_sale)
			begin
				@(posedge CLK);
				door_open <= 1'b1;
				await_output(w_vend_low, 2);
				@(posedge CLK);
				door_open <= 1'b0;
			end
			else
				await_output(w_vend_low, `ENTRY_WINDOW + 2);
		end
		// COST clears only once the machine is back in idle
		await_output(w_cost_clear, 4);
		expected_cost = '0;
	endtask

	initial
	begin : stimulus
		int slot_a;
		int slot_b;
		int verdict;
		RESET <= 1'b1;
		card_in <= 1'b0;
		valid_tran <= 1'b0;
		key_press <= 1'b0;
		door_open <= 1'b0;
		reload <= 1'b0;
		item_code <= '0;
		errors = 0;
		expected_cost = '0;
		lfsr_q = 16'd21900;
		foreach (model_stock[i])
			model_stock[i] = 0;
		repeat (16) @(posedge CLK);
		RESET <= 1'b0;
		repeat (2) @(posedge CLK);

		// Every slot is empty after reset
		purchase(next_slot(), full_sale);

		// Full sale of a random slot after a reload
		pulse_input(p_reload, 0);
		foreach (model_stock[i])
			model_stock[i] = `STOCK_FULL;
		slot_a = next_slot();
		purchase(slot_a, full_sale);

		// Codes past the last slot, then a card with no digits at all
		for (int code = `SLOT_COUNT; code < 100; code++)
			purchase(code, full_sale);
		pulse_input(p_card, 0);
		selection_verdict(14, verdict);
		assert (verdict == 1)
		else
			log_mismatch("INVALID_SEL", int'(verdict == 1), 1);

		// A declined sale leaves the stock alone, so ten sales then drain the slot
		slot_b = next_slot();
		if (slot_b == slot_a)
			slot_b = (slot_b + 1) % `SLOT_COUNT;
		purchase(slot_b, no_approval);
		for (int n = 0; n <= `STOCK_FULL; n++)
			purchase(slot_b, full_sale);
		pulse_input(p_reload, 0);
		foreach (model_stock[i])
			model_stock[i] = `STOCK_FULL;
		purchase(slot_b, full_sale);

		// The door never opens, then the next card must work normally
		slot_a = next_slot();
		purchase(slot_a, door_left_shut);
		purchase(slot_a, full_sale);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		fail_check("the watchdog expired before the tests finished");
		$display("Errors: %0d", errors);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/vending_pkg.sv
design/window_timer.sv
design/key_entry.sv
design/slot_inventory.sv
design/vend_sequencer.sv
design/vending_machine.sv
test/vending_machine_tb.sv
